// File: Makefile
# Verilator build and run for the SPI target testbench

SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := spi_target_tb
FILELIST := sources.f
OBJ_DIR  := obj_dir
PASS_MSG := No errors

BIN      := $(OBJ_DIR)/V$(TOP)
SOURCES  := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# Fails unless the pass message shows up in the output
run: $(BIN)
	@out="$$(./$(BIN) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^$(PASS_MSG)$$"

clean:
	rm -rf $(OBJ_DIR)

// File: sources.f
verilog/spi_pkg.sv
verilog/spi_xfer_if.sv
verilog/spi_pin_sync.sv
verilog/byte_fifo.sv
verilog/spi_shifter.sv
verilog/spi_layer.sv
verilog/spi_target.sv
verification/spi_target_tb.sv

// File: verification/spi_target_tb.sv
`default_nettype none

module spi_target_tb;

  localparam spi_pkg::byte_t HEADER = 8'ha7;
  localparam int             BYTES  = 16;
  localparam int             PERIOD = 8;
  localparam int             FRAMES = 4;

  logic           clock    = 1'b0;
  logic           reset    = 1'b1;
  spi_pkg::byte_t status   = 8'h5c;
  logic           s_tvalid = 1'b0;
  logic           s_tlast  = 1'b0;
  spi_pkg::byte_t s_tdata  = 8'h00;
  logic           m_tready = 1'b0;
  logic           sck      = 1'b0;  // Mode 0 idle level
  logic           ssel     = 1'b1;
  logic           mosi     = 1'b0;
  logic           s_tready, m_tvalid, m_tlast, miso, overflow, underrun;
  spi_pkg::byte_t m_tdata;

  spi_pkg::byte_t tx_model [$];  // Bytes waiting in the DUT Tx FIFO
  spi_pkg::byte_t rx_expect [$]; // MOSI bytes still to come out
  logic           frame_seen   = 1'b0;
  logic           ready_hold   = 1'b0;  // Holds m_tready low
  logic           underrun_exp = 1'b0;
  logic           overflow_exp = 1'b0;
  string          rx_test      = "rx_order";

  always #(PERIOD / 2) clock = ~clock;

  spi_target #(.HEADER(HEADER), .BYTES(BYTES)) spi_target_i (
    .clock      (clock),
    .reset      (reset),
    .status_i   (status),
    .overflow_o (overflow),
    .underrun_o (underrun),
    .s_tvalid_i (s_tvalid),
    .s_tready_o (s_tready),
    .s_tlast_i  (s_tlast),
    .s_tdata_i  (s_tdata),
    .m_tvalid_o (m_tvalid),
    .m_tready_i (m_tready),
    .m_tlast_o  (m_tlast),
    .m_tdata_o  (m_tdata),
    .sck_i      (sck),
    .ssel_i     (ssel),
    .mosi_i     (mosi),
    .miso_o     (miso)
  );

  // ------------------------------------------------------------
  // Failure reporting
  // ------------------------------------------------------------
  task automatic value_mismatch(input string test, input spi_pkg::byte_t expected,
                                input spi_pkg::byte_t actual);
    $display("[ERROR] %s: expected 0x%02h, actual 0x%02h", test, expected, actual);
    $display("Errors found");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic stop_with_message(input string msg);
    $display("Failure: %s", msg);
    $display("Errors found");
    $fatal(1, "stopped at the first error");
  endtask

  // ------------------------------------------------------------
  // Stream source, SPI master and checks
  // ------------------------------------------------------------
  task automatic send_stream(input int count);
    spi_pkg::byte_t v;
    int             i;
    for (i = 0; i < count; i++) begin
      v = spi_pkg::byte_t'($urandom);
      s_tvalid <= 1'b1;
      s_tdata  <= v;
      tx_model.push_back(v);
      @(negedge clock);
      while (!s_tready) @(negedge clock);  // Low while status is primed
      @(posedge clock);                    // Byte taken on this edge
    end
    s_tvalid <= 1'b0;
  endtask

  task automatic run_frame(input string test, input int nbytes);
    spi_pkg::byte_t mo, mi, exp_b;
    int             b, i;
    frame_seen = 1'b1;
    ssel <= 1'b0;
    repeat (2) @(posedge clock);
    for (b = 0; b < nbytes; b++) begin
      mo = spi_pkg::byte_t'($urandom);
      rx_expect.push_back(mo);
      if (b == 0) begin
        exp_b = HEADER;
      end else if (tx_model.size() == 0) begin
        exp_b        = 8'h00;  // Zero fill
        underrun_exp = 1'b1;
      end else begin
        exp_b = tx_model.pop_front();
      end
      for (i = 7; i >= 0; i--) begin
        mosi <= mo[i];                 // Changes with the falling SCK
        repeat (4) @(posedge clock);
        sck <= 1'b1;
        repeat (3) @(posedge clock);
        @(negedge clock);
        mi[i] = miso;                  // Stable for the whole high half
        @(posedge clock);
        sck <= 1'b0;
      end
      assert (mi == exp_b) else value_mismatch((b == 0) ? "header" : test, exp_b, mi);
    end
    // Last fall of the frame loads one more Tx byte that never goes out
    if (tx_model.size() == 0) underrun_exp = 1'b1;
    else void'(tx_model.pop_front());
    repeat (6) @(posedge clock);
    ssel <= 1'b1;
    repeat (8) @(posedge clock);
  endtask

  task automatic check_flags(input string test);
    @(negedge clock);
    assert (underrun == underrun_exp)
      else value_mismatch({test, " underrun_o"}, {7'd0, underrun_exp}, {7'd0, underrun});
    assert (overflow == overflow_exp)
      else value_mismatch({test, " overflow_o"}, {7'd0, overflow_exp}, {7'd0, overflow});
    @(posedge clock);
  endtask

  // Wait for the Rx side to empty; then the FSM primes the next status byte
  task automatic drain_rx();
    while (rx_expect.size() != 0) @(posedge clock);
    repeat (5) @(posedge clock);
    tx_model.push_back(status);
    status <= spi_pkg::byte_t'($urandom);
  endtask

  always @(posedge clock) begin
    m_tready <= ready_hold ? 1'b0 : 1'($urandom);  // Random back-pressure
  end

  // Output stream sink takes one byte per valid/ready handshake
  always @(negedge clock) begin
    if (!reset && m_tvalid && m_tready) begin
      if (rx_expect.size() == 0) begin
        stop_with_message("byte on m_tdata_o with none expected");
      end else begin
        assert (m_tdata == rx_expect[0]) else value_mismatch(rx_test, rx_expect[0], m_tdata);
        void'(rx_expect.pop_front());
      end
    end
  end

  a_tlast_low: assert property (@(posedge clock) !m_tlast)
    else stop_with_message("m_tlast_o went high");

  a_reset_state: assert property (@(posedge clock) disable iff (reset)
    !frame_seen |-> !(m_tvalid || overflow || underrun || miso))
    else stop_with_message("outputs not inactive after reset");

  a_flags_sticky: assert property (@(posedge clock) disable iff (reset)
    !($fell(underrun) || $fell(overflow)))
    else stop_with_message("an error flag cleared without reset");

  initial begin
    #((FRAMES * (BYTES + 3) * 64 + 2000) * PERIOD);
    stop_with_message("watchdog expired before the tests finished");
  end

  // ------------------------------------------------------------
  // Test sequence
  // ------------------------------------------------------------
  initial begin
    void'($urandom(32'hb7bafabf));
    tx_model.push_back(status);  // Primed right after reset
    repeat (16) @(posedge clock);
    reset <= 1'b0;
    repeat (4) @(posedge clock);

    send_stream(5);              // Header, status, then the stream
    run_frame("tx_order", 6);
    check_flags("tx_order");
    drain_rx();

    send_stream(4);
    run_frame("tx_order", 5);
    check_flags("tx_order");
    drain_rx();

    send_stream(2);              // Two short of the frame length
    run_frame("underrun", 6);
    check_flags("underrun");
    drain_rx();

    ready_hold <= 1'b1;
    repeat (3) @(posedge clock);
    rx_test = "overflow";
    run_frame("overflow", BYTES + 3);
    repeat (3) void'(rx_expect.pop_back());  // Dropped by the full FIFO
    overflow_exp = 1'b1;
    check_flags("overflow");
    ready_hold <= 1'b0;
    drain_rx();
    repeat (8) @(posedge clock);

    $display("No errors");
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog/byte_fifo.sv
`default_nettype none

module byte_fifo #(
  parameter int BYTES = 16  // Depth in bytes as a power of two
) (
  input  wire             clock,
  input  wire             reset,
  input  wire             push_i,
  input  wire  spi_pkg::byte_t data_i,
  input  wire             pop_i,
  output spi_pkg::byte_t  data_o,   // First-word fall-through head
  output logic            empty_o,
  output logic            full_o
);

  localparam int AW = $clog2(BYTES);

  // Byte storage
  spi_pkg::byte_t mem [BYTES];

  // Pointers carry one wrap bit above the address
  logic [AW:0] wr_ptr, rd_ptr;
  logic [AW:0] level;

  assign level   = wr_ptr - rd_ptr;
  assign empty_o = (wr_ptr == rd_ptr);
  assign full_o  = (wr_ptr[AW] != rd_ptr[AW]) &&
                   (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
  assign data_o  = mem[rd_ptr[AW-1:0]];

  // ----------------------------------------------------------
  // Pointer update
  // ----------------------------------------------------------
  always_ff @(posedge clock) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (push_i) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop_i) begin
        rd_ptr <= rd_ptr + 1'b1;  // Head moves on next cycle
      end
    end
  end

  always_ff @(posedge clock) begin
    if (push_i) begin
      mem[wr_ptr[AW-1:0]] <= data_i;
    end
  end

  // ----------------------------------------------------------
  // Checks
  // ----------------------------------------------------------
  // Callers gate their strobes with the flags
  a_no_push_full: assert property (
    @(posedge clock) disable iff (reset) push_i |-> !full_o
  ) else $error("byte_fifo push while full");

  a_no_pop_empty: assert property (
    @(posedge clock) disable iff (reset) pop_i |-> !empty_o
  ) else $error("byte_fifo pop while empty");

  // Occupancy never passes the depth
  a_level: assert property (
    @(posedge clock) disable iff (reset) level <= (AW + 1)'(BYTES)
  ) else $error("byte_fifo occupancy out of range");

endmodule

`default_nettype wire

// File: verilog/spi_layer.sv
`default_nettype none

module spi_layer #(
  parameter spi_pkg::byte_t HEADER = 8'ha7,
  parameter int             BYTES  = 16
) (
  input  wire        clock,
  input  wire        reset,
  spi_xfer_if.layer  xfer,
  input  wire        sck_i,
  input  wire        ssel_i,
  input  wire        mosi_i,
  output logic       miso_o,
  output logic       overflow_o,   // Sticky, Rx byte dropped
  output logic       underrun_o    // Sticky, zero byte sent
);

  // Pin side
  logic sck_rise, sck_fall, frame_start, ssel_active, mosi_bit;

  // Tx FIFO
  logic           tx_push, tx_pop, tx_empty, tx_full;
  spi_pkg::byte_t tx_head;

  // Rx FIFO
  logic           rx_valid, rx_push, rx_empty, rx_full;
  spi_pkg::byte_t rx_byte;

  logic underrun_pulse;

  // ----------------------------------------------------------
  // Pins to shifter
  // ----------------------------------------------------------
  spi_pin_sync sync_i (
    .clock         (clock),
    .reset         (reset),
    .sck_i         (sck_i),
    .ssel_i        (ssel_i),
    .mosi_i        (mosi_i),
    .sck_rise_o    (sck_rise),
    .sck_fall_o    (sck_fall),
    .frame_start_o (frame_start),
    .ssel_active_o (ssel_active),
    .mosi_bit_o    (mosi_bit)
  );

  spi_shifter #(
    .HEADER (HEADER)
  ) shifter_i (
    .clock         (clock),
    .reset         (reset),
    .sck_rise_i    (sck_rise),
    .sck_fall_i    (sck_fall),
    .frame_start_i (frame_start),
    .ssel_active_i (ssel_active),
    .mosi_bit_i    (mosi_bit),
    .tx_empty_i    (tx_empty),
    .tx_data_i     (tx_head),
    .tx_pop_o      (tx_pop),
    .rx_valid_o    (rx_valid),
    .rx_data_o     (rx_byte),
    .underrun_o    (underrun_pulse),
    .miso_o        (miso_o)
  );

  // ----------------------------------------------------------
  // FIFOs
  // ----------------------------------------------------------
  assign tx_push = xfer.rdy & ~tx_full;
  assign rx_push = rx_valid & ~rx_full;  // Byte lost when full

  byte_fifo #(
    .BYTES (BYTES)
  ) tx_fifo_i (
    .clock   (clock),
    .reset   (reset),
    .push_i  (tx_push),
    .data_i  (xfer.tx_data),
    .pop_i   (tx_pop),
    .data_o  (tx_head),
    .empty_o (tx_empty),
    .full_o  (tx_full)
  );

  byte_fifo #(
    .BYTES (BYTES)
  ) rx_fifo_i (
    .clock   (clock),
    .reset   (reset),
    .push_i  (rx_push),
    .data_i  (rx_byte),
    .pop_i   (xfer.ack),
    .data_o  (xfer.rx_data),
    .empty_o (rx_empty),
    .full_o  (rx_full)
  );

  // Link status toward the transaction FSM
  assign xfer.cyc = ssel_active;
  assign xfer.get = ~tx_full;
  assign xfer.wat = rx_empty;

  // Sticky error flags, only reset clears them
  always_ff @(posedge clock) begin
    if (reset) begin
      overflow_o <= 1'b0;
      underrun_o <= 1'b0;
    end else begin
      if (rx_valid && rx_full) begin
        overflow_o <= 1'b1;
      end
      if (underrun_pulse) begin
        underrun_o <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: verilog/spi_pin_sync.sv
`default_nettype none

module spi_pin_sync (
  input  wire  clock,
  input  wire  reset,
  input  wire  sck_i,
  input  wire  ssel_i,
  input  wire  mosi_i,
  output logic sck_rise_o,     // One-cycle pulse per SCK rise in a frame
  output logic sck_fall_o,     // One-cycle pulse per SCK fall in a frame
  output logic frame_start_o,  // One-cycle pulse when SSEL goes low
  output logic ssel_active_o,  // Frame in progress
  output logic mosi_bit_o      // MOSI aligned with the edge pulses
);

  logic sck_meta, sck_sync, sck_prev;
  logic ssel_meta, ssel_sync;
  logic mosi_meta, mosi_sync;

  // ----------------------------------------------------------
  // Two-flop synchronizers and edge detection
  // ----------------------------------------------------------
  always_ff @(posedge clock) begin
    if (reset) begin
      sck_meta      <= 1'b0;  // SCK idles low in mode 0
      sck_sync      <= 1'b0;
      sck_prev      <= 1'b0;
      ssel_meta     <= 1'b1;  // SSEL idles high
      ssel_sync     <= 1'b1;
      sck_rise_o    <= 1'b0;
      sck_fall_o    <= 1'b0;
      frame_start_o <= 1'b0;
      ssel_active_o <= 1'b0;
    end else begin
      sck_meta  <= sck_i;
      sck_sync  <= sck_meta;
      sck_prev  <= sck_sync;
      ssel_meta <= ssel_i;
      ssel_sync <= ssel_meta;

      // Edges only count inside a frame
      sck_rise_o    <= sck_sync & ~sck_prev & ~ssel_sync;
      sck_fall_o    <= ~sck_sync & sck_prev & ~ssel_sync;
      // Previous active level still low => SSEL just fell
      frame_start_o <= ~ssel_sync & ~ssel_active_o;
      ssel_active_o <= ~ssel_sync;
    end
  end

  // One extra stage keeps MOSI in step with the registered edge pulses
  always_ff @(posedge clock) begin
    mosi_meta  <= mosi_i;
    mosi_sync  <= mosi_meta;
    mosi_bit_o <= mosi_sync;
  end

endmodule

`default_nettype wire

// File: verilog/spi_pkg.sv
`default_nettype none

package spi_pkg;

  // One SPI data byte, MSB first on the wire
  typedef logic [7:0] byte_t;

  // Transaction FSM of the top level
  typedef enum logic [1:0] {
    ST_FILL = 2'd0,  // Prime the Tx FIFO with the status byte
    ST_IDLE = 2'd1,  // Wait for the first received byte
    ST_XFER = 2'd2   // Frame in progress
  } target_state_e;

  // Source of the byte being shifted out on MISO
  typedef enum logic {
    PH_HEADER = 1'b0,  // Fixed header byte
    PH_DATA   = 1'b1   // Bytes popped from the Tx FIFO
  } shift_phase_e;

endpackage

`default_nettype wire

// File: verilog/spi_shifter.sv
`default_nettype none

module spi_shifter #(
  parameter spi_pkg::byte_t HEADER = 8'ha7
) (
  input  wire             clock,
  input  wire             reset,
  input  wire             sck_rise_i,
  input  wire             sck_fall_i,
  input  wire             frame_start_i,
  input  wire             ssel_active_i,
  input  wire             mosi_bit_i,
  input  wire             tx_empty_i,
  input  wire  spi_pkg::byte_t tx_data_i,
  output logic            tx_pop_o,     // Take the Tx FIFO head
  output logic            rx_valid_o,   // One-cycle strobe per complete byte
  output spi_pkg::byte_t  rx_data_o,
  output logic            underrun_o,   // Pulse when there is nothing to send
  output logic            miso_o
);

  logic [2:0]            bit_cnt;   // Rises seen in the current byte
  spi_pkg::byte_t        rx_shift;
  spi_pkg::byte_t        tx_shift;
  logic                  byte_edge;

  // In mode 0 the fall after the eighth rise closes a byte,
  // so the next byte goes out from there
  assign byte_edge  = sck_fall_i && (bit_cnt == 3'd0);
  assign tx_pop_o   = byte_edge & ~tx_empty_i;
  assign underrun_o = byte_edge & tx_empty_i;

  assign rx_data_o  = rx_shift;  // Holds the full byte while rx_valid is up

  // Header MSB appears in the frame_start cycle itself
  assign miso_o = frame_start_i ? HEADER[7] :
                  ssel_active_i ? tx_shift[7] : 1'b0;

  // ----------------------------------------------------------
  // Bit counter and Rx strobe
  // ----------------------------------------------------------
  always_ff @(posedge clock) begin
    if (reset) begin
      bit_cnt    <= 3'd0;
      rx_valid_o <= 1'b0;
    end else begin
      rx_valid_o <= 1'b0;
      if (frame_start_i) begin
        bit_cnt <= 3'd0;  // Drops any partial byte of the last frame
      end else if (sck_rise_i) begin
        bit_cnt    <= bit_cnt + 3'd1;
        rx_valid_o <= (bit_cnt == 3'd7);  // Eighth rise
      end
    end
  end

  // ----------------------------------------------------------
  // Shift registers
  // ----------------------------------------------------------
  always_ff @(posedge clock) begin
    if (frame_start_i) begin
      tx_shift <= HEADER;
    end else if (byte_edge) begin
      tx_shift <= tx_empty_i ? 8'h00 : tx_data_i;  // Zero fill on underrun
    end else if (sck_fall_i) begin
      tx_shift <= {tx_shift[6:0], 1'b0};
    end

    if (sck_rise_i) begin
      rx_shift <= {rx_shift[6:0], mosi_bit_i};  // MSB first
    end
  end

  // Received bytes only come out while SSEL is low
  a_rx_in_frame: assert property (
    @(posedge clock) disable iff (reset) rx_valid_o |-> ssel_active_i
  ) else $error("spi_shifter rx_valid outside a frame");

endmodule

`default_nettype wire

// File: verilog/spi_target.sv
`default_nettype none

module spi_target #(
  parameter spi_pkg::byte_t HEADER = 8'ha7,  // First byte of every frame
  parameter int             BYTES  = 16      // Depth of each FIFO
) (
  input  wire             clock,
  input  wire             reset,
  input  wire  spi_pkg::byte_t status_i,

  // Error flags
  output logic            overflow_o,
  output logic            underrun_o,

  // Byte stream in, sent to the master
  input  wire             s_tvalid_i,
  output logic            s_tready_o,
  input  wire             s_tlast_i,   // No framing use here
  input  wire  spi_pkg::byte_t s_tdata_i,

  // Byte stream out, received from the master
  output logic            m_tvalid_o,
  input  wire             m_tready_i,
  output logic            m_tlast_o,
  output spi_pkg::byte_t  m_tdata_o,

  // SPI pins
  input  wire             sck_i,
  input  wire             ssel_i,
  input  wire             mosi_i,
  output logic            miso_o
);

  spi_pkg::target_state_e state;

  spi_xfer_if xfer ();

  // ----------------------------------------------------------
  // Stream mapping
  // ----------------------------------------------------------
  // Status byte goes first, the stream waits until it is in
  assign xfer.rdy     = (state == spi_pkg::ST_FILL) || s_tvalid_i;
  assign xfer.tx_data = (state == spi_pkg::ST_FILL) ? status_i : s_tdata_i;
  assign s_tready_o   = xfer.get && (state != spi_pkg::ST_FILL);

  assign m_tvalid_o = ~xfer.wat;
  assign xfer.ack   = m_tready_i & ~xfer.wat;
  assign m_tlast_o  = 1'b0;  // Frames carry no packet boundary
  assign m_tdata_o  = xfer.rx_data;

  // ----------------------------------------------------------
  // Transaction FSM
  // ----------------------------------------------------------
  always_ff @(posedge clock) begin
    if (reset) begin
      state <= spi_pkg::ST_FILL;
    end else begin
      case (state)
        spi_pkg::ST_FILL: begin
          if (xfer.get) begin
            state <= spi_pkg::ST_IDLE;  // Status byte pushed this cycle
          end
        end
        spi_pkg::ST_IDLE: begin
          if (xfer.cyc && !xfer.wat) begin
            state <= spi_pkg::ST_XFER;  // First byte from the master
          end
        end
        spi_pkg::ST_XFER: begin
          // Frame over and Rx side drained, prime again
          if (!xfer.cyc && xfer.wat) begin
            state <= spi_pkg::ST_FILL;
          end
        end
        default: begin
          state <= spi_pkg::ST_FILL;
        end
      endcase
    end
  end

  spi_layer #(
    .HEADER (HEADER),
    .BYTES  (BYTES)
  ) layer_i (
    .clock      (clock),
    .reset      (reset),
    .xfer       (xfer.layer),
    .sck_i      (sck_i),
    .ssel_i     (ssel_i),
    .mosi_i     (mosi_i),
    .miso_o     (miso_o),
    .overflow_o (overflow_o),
    .underrun_o (underrun_o)
  );

  a_state_legal: assert property (
    @(posedge clock) disable iff (reset)
    state inside {spi_pkg::ST_FILL, spi_pkg::ST_IDLE, spi_pkg::ST_XFER}
  ) else $error("spi_target FSM in an illegal state");

endmodule

`default_nettype wire

// File: verilog/spi_xfer_if.sv
`default_nettype none

// Byte-level link between the transaction FSM and the SPI layer
interface spi_xfer_if;

  logic           cyc;      // Frame active
  logic           get;      // Tx FIFO has room
  logic           wat;      // Rx FIFO empty
  spi_pkg::byte_t rx_data;  // Rx FIFO head

  logic           rdy;      // Tx byte offered
  spi_pkg::byte_t tx_data;  // Offered Tx byte
  logic           ack;      // Pop the Rx FIFO

  // Transaction FSM side
  modport target (
    input  cyc,
    input  get,
    input  wat,
    input  rx_data,
    output rdy,
    output tx_data,
    output ack
  );

  // SPI layer side
  modport layer (
    output cyc,
    output get,
    output wat,
    output rx_data,
    input  rdy,
    input  tx_data,
    input  ack
  );

endinterface

`default_nettype wire
